// File: logic/core_params.svh
/*
 * Width and size macros for the integer pipeline core.
 * Included by the package and by every RTL file that sizes a signal.
 */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Data and address width
`define XLEN 32

// Integer register file
`define REG_COUNT 32
`define REG_ADDR_W 5

// Instruction fields
`define OPCODE_W 7

`endif

// File: logic/core_pkg.sv
/*
 * Shared types of the core: opcode and ALU enums and the stage structs.
 * Imported by each module that passes these types across a boundary.
 */
`include "core_params.svh"

package core_pkg;

    typedef logic [`XLEN-1:0] xlen_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // Major opcode classes, standard RV32I values
    typedef enum logic [`OPCODE_W-1:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_STORE  = 7'b0100011,
        OPC_OTHER  = 7'b0000000
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5
    } alu_op_e;

    // Decoded control set handed to execute
    typedef struct packed {
        alu_op_e   alu_op;
        logic      use_imm;
        logic      is_store;
        logic      rd_we;
        reg_addr_t rd_addr;
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
        xlen_t     imm;
    } exe_ctrl_t;

    // Writeback register, also drives the store strobe
    typedef struct packed {
        logic      rd_we;
        reg_addr_t rd_addr;
        xlen_t     result;
        logic      store_we;
        xlen_t     store_addr;
        xlen_t     store_data;
    } wrb_t;

endpackage : core_pkg

// File: logic/id2exe_if.sv
/*
 * Decode to execute bundle, one valid strobe per instruction.
 * Decode drives it, execute samples it on the next edge.
 */
interface id2exe_if
    import core_pkg::*;
();

    logic      valid;
    exe_ctrl_t ctrl;
    xlen_t     rs1_data;
    xlen_t     rs2_data;

    modport decode (
        output valid,
        output ctrl,
        output rs1_data,
        output rs2_data
    );

    modport execute (
        input valid,
        input ctrl,
        input rs1_data,
        input rs2_data
    );

endinterface : id2exe_if

// File: logic/reg_file.sv
/*
 * Integer register file, two read ports and one write port.
 * Same-cycle writes pass straight through to the read ports.
 */
`include "core_params.svh"

module reg_file
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  reg_addr_t rs1_addr_i,
    input  reg_addr_t rs2_addr_i,
    output xlen_t     rs1_data_o,
    output xlen_t     rs2_data_o,

    input  logic      wr_en_i,
    input  reg_addr_t wr_addr_i,
    input  xlen_t     wr_data_i
);

    // x0 has no storage
    xlen_t regs_q [1:`REG_COUNT-1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en_i && (wr_addr_i != '0)) begin
            regs_q[wr_addr_i] <= wr_data_i;
        end
    end

    function automatic xlen_t read_port(input reg_addr_t addr);
        xlen_t data;
        if (addr == '0) begin
            data = '0;
        end else if (wr_en_i && (wr_addr_i == addr)) begin
            // Writeback lands this cycle
            data = wr_data_i;
        end else begin
            data = regs_q[addr];
        end
        return data;
    endfunction

    always_comb begin
        rs1_data_o = read_port(rs1_addr_i);
        rs2_data_o = read_port(rs2_addr_i);
    end

endmodule : reg_file

// File: logic/instr_decode.sv
/*
 * Decode stage: registers the incoming instruction and builds the
 * control bundle for execute, with operands read from the register file.
 */
`include "core_params.svh"

module instr_decode
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  logic      instr_valid_i,
    input  xlen_t     instr_i,

    // Register file read ports
    output reg_addr_t rs1_addr_o,
    output reg_addr_t rs2_addr_o,
    input  xlen_t     rs1_data_i,
    input  xlen_t     rs2_data_i,

    id2exe_if.decode  id2exe
);

    // RV32I funct fields for the kept instructions
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;
    localparam logic [2:0] F3_SW      = 3'b010;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_SUB     = 7'b0100000;

    logic    valid_q;
    xlen_t   instr_q;

    opcode_e opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xlen_t   imm_i;
    xlen_t   imm_s;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= instr_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        instr_q <= instr_i;
    end

    assign opcode = opcode_e'(instr_q[`OPCODE_W-1:0]);
    assign funct3 = instr_q[14:12];
    assign funct7 = instr_q[31:25];
    assign imm_i  = {{20{instr_q[31]}}, instr_q[31:20]};
    assign imm_s  = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};

    assign rs1_addr_o = instr_q[19:15];
    assign rs2_addr_o = instr_q[24:20];

    always_comb begin
        id2exe.ctrl          = '0;
        id2exe.ctrl.alu_op   = ALU_ADD;
        id2exe.ctrl.rd_addr  = instr_q[11:7];
        id2exe.ctrl.rs1_addr = instr_q[19:15];
        id2exe.ctrl.rs2_addr = instr_q[24:20];
        id2exe.ctrl.imm      = imm_i;

        case (opcode)
            OPC_OP: begin
                // SUB is the only funct7 variant kept
                id2exe.ctrl.rd_we = (funct7 == F7_BASE) ||
                                    ((funct7 == F7_SUB) && (funct3 == F3_ADD_SUB));
                case (funct3)
                    F3_ADD_SUB: id2exe.ctrl.alu_op = (funct7 == F7_SUB) ? ALU_SUB : ALU_ADD;
                    F3_SLT:     id2exe.ctrl.alu_op = ALU_SLT;
                    F3_XOR:     id2exe.ctrl.alu_op = ALU_XOR;
                    F3_OR:      id2exe.ctrl.alu_op = ALU_OR;
                    F3_AND:     id2exe.ctrl.alu_op = ALU_AND;
                    default:    id2exe.ctrl.rd_we  = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                id2exe.ctrl.use_imm = 1'b1;
                id2exe.ctrl.rd_we   = 1'b1;
                case (funct3)
                    F3_ADD_SUB: id2exe.ctrl.alu_op = ALU_ADD;
                    F3_XOR:     id2exe.ctrl.alu_op = ALU_XOR;
                    F3_OR:      id2exe.ctrl.alu_op = ALU_OR;
                    F3_AND:     id2exe.ctrl.alu_op = ALU_AND;
                    // SLTI and shifts are not supported
                    default:    id2exe.ctrl.rd_we  = 1'b0;
                endcase
            end
            OPC_STORE: begin
                // Address is rs1 plus the S-type offset
                id2exe.ctrl.use_imm  = 1'b1;
                id2exe.ctrl.imm      = imm_s;
                id2exe.ctrl.is_store = (funct3 == F3_SW);
            end
            default: begin
                id2exe.ctrl.rd_we    = 1'b0;
                id2exe.ctrl.is_store = 1'b0;
            end
        endcase
    end

    assign id2exe.valid    = valid_q;
    assign id2exe.rs1_data = rs1_data_i;
    assign id2exe.rs2_data = rs2_data_i;

endmodule : instr_decode

// File: logic/int_execute.sv
/*
 * Execute and writeback: latches the decoded bundle, forwards from the
 * writeback register, runs the ALU and registers the result or store.
 */
`include "core_params.svh"

module int_execute
    import core_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    id2exe_if.execute  id2exe,

    output wrb_t       wrb_o
);

    // Decode/execute pipeline register
    logic      ex_valid_q;
    exe_ctrl_t ex_ctrl_q;
    xlen_t     ex_rs1_q;
    xlen_t     ex_rs2_q;

    logic      fwd_rs1;
    logic      fwd_rs2;
    xlen_t     op_a;
    xlen_t     rs2_val;
    xlen_t     op_b;
    xlen_t     alu_result;
    logic      slt_bit;

    wrb_t      wrb_d;
    wrb_t      wrb_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid_q <= 1'b0;
        end else begin
            ex_valid_q <= id2exe.valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_ctrl_q <= id2exe.ctrl;
        ex_rs1_q  <= id2exe.rs1_data;
        ex_rs2_q  <= id2exe.rs2_data;
    end

    // Instruction one ahead sits in the writeback register
    // Older results already come through the register file
    assign fwd_rs1 = wrb_q.rd_we && (wrb_q.rd_addr != '0) &&
                     (wrb_q.rd_addr == ex_ctrl_q.rs1_addr);
    assign fwd_rs2 = wrb_q.rd_we && (wrb_q.rd_addr != '0) &&
                     (wrb_q.rd_addr == ex_ctrl_q.rs2_addr);

    assign op_a    = fwd_rs1 ? wrb_q.result : ex_rs1_q;
    assign rs2_val = fwd_rs2 ? wrb_q.result : ex_rs2_q;
    assign op_b    = ex_ctrl_q.use_imm ? ex_ctrl_q.imm : rs2_val;

    assign slt_bit = $signed(op_a) < $signed(op_b);

    always_comb begin
        case (ex_ctrl_q.alu_op)
            ALU_ADD: alu_result = op_a + op_b;
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_XOR: alu_result = op_a ^ op_b;
            ALU_SLT: alu_result = {{(`XLEN-1){1'b0}}, slt_bit};
            default: alu_result = '0;
        endcase
    end

    always_comb begin
        wrb_d.rd_we      = ex_valid_q && ex_ctrl_q.rd_we;
        wrb_d.rd_addr    = ex_ctrl_q.rd_addr;
        wrb_d.result     = alu_result;
        // Store address comes out of the same adder
        wrb_d.store_we   = ex_valid_q && ex_ctrl_q.is_store;
        wrb_d.store_addr = alu_result;
        wrb_d.store_data = rs2_val;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wrb_q.rd_we    <= 1'b0;
            wrb_q.store_we <= 1'b0;
        end else begin
            wrb_q <= wrb_d;
        end
    end

    assign wrb_o = wrb_q;

endmodule : int_execute

// File: logic/core_top.sv
/*
 * Top level of the three-stage RV32I integer core.
 * Takes one instruction strobe per cycle and emits SW as a store strobe.
 */
`include "core_params.svh"

module core_top
    import core_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,

    // Instruction strobe
    input  logic             instr_valid_i,
    input  logic [`XLEN-1:0] instr_i,

    // Store strobe, address and data valid with dbus_we_o
    output logic             dbus_we_o,
    output logic [`XLEN-1:0] dbus_addr_o,
    output logic [`XLEN-1:0] dbus_wdata_o
);

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    wrb_t      wrb;

    id2exe_if u_id2exe ();

    instr_decode u_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .id2exe        (u_id2exe)
    );

    int_execute u_execute (
        .clk    (clk),
        .rst_n  (rst_n),
        .id2exe (u_id2exe),
        .wrb_o  (wrb)
    );

    // Write port fed straight from the writeback register
    reg_file u_reg_file (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wr_en_i    (wrb.rd_we),
        .wr_addr_i  (wrb.rd_addr),
        .wr_data_i  (wrb.result)
    );

    assign dbus_we_o    = wrb.store_we;
    assign dbus_addr_o  = wrb.store_addr;
    assign dbus_wdata_o = wrb.store_data;

endmodule : core_top

// File: verif/core_tb.sv
/*
 * Testbench for the integer core: random RV32I streams against a
 * register model, with every store strobe checked by address, data and cycle.
 */
`include "core_params.svh"

module core_tb
    import core_pkg::*;
();

    localparam int RESET_CYCLES = 16;
    localparam int IDLE_CYCLES  = 10;
    localparam int POOL         = 4;
    localparam int N_RR         = 40;
    localparam int N_IMM        = 40;
    localparam int N_X0         = 10;
    localparam int N_GAP        = 30;
    localparam int MAX_GAP      = 3;
    localparam int N_UNK        = 30;
    localparam int TEST_TAIL    = 5;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + 20
        + (IDLE_CYCLES + `REG_COUNT + TEST_TAIL)
        + (POOL + 2 * N_RR + TEST_TAIL)
        + (2 * N_IMM + TEST_TAIL)
        + (2 * N_X0 + TEST_TAIL)
        + (2 * N_GAP * (1 + MAX_GAP) + TEST_TAIL)
        + (2 * N_UNK + TEST_TAIL);

    // Standard RV32I major opcodes, kept apart from the DUT package
    localparam logic [6:0] RV_OP     = 7'b0110011;
    localparam logic [6:0] RV_OP_IMM = 7'b0010011;
    localparam logic [6:0] RV_STORE  = 7'b0100011;

    typedef struct packed {
        logic [31:0] due;
        xlen_t       addr;
        xlen_t       data;
    } exp_store_t;

    logic  clk;
    logic  rst_n;
    logic  instr_valid_i;
    xlen_t instr_i;
    logic  dbus_we_o;
    xlen_t dbus_addr_o;
    xlen_t dbus_wdata_o;

    integer      seed;
    logic [31:0] cycle_cnt;
    int          checks;
    int          errors;
    int          err_mark;
    xlen_t       model_regs [0:`REG_COUNT-1];
    exp_store_t  exp_q [$];

    core_top u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .dbus_we_o     (dbus_we_o),
        .dbus_addr_o   (dbus_addr_o),
        .dbus_wdata_o  (dbus_wdata_o)
    );

    always #2 clk = ~clk;

    // Cycle count and run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic check_store(input xlen_t got_addr, input xlen_t exp_addr,
                               input xlen_t got_data, input xlen_t exp_data);
        checks++;
        if (got_addr !== exp_addr || got_data !== exp_data) begin
            errors++;
            $display("mismatch at %0t: store addr %h data %h, expected addr %h data %h",
                     $time, got_addr, got_data, exp_addr, exp_data);
        end
    endtask

    // Store strobes sampled mid-cycle, away from the drive point
    always @(negedge clk) begin
        if (rst_n) begin
            if (dbus_we_o) begin
                if (exp_q.size() == 0 || exp_q[0].due != cycle_cnt) begin
                    errors++;
                    $display("store strobe at time %0t was not expected in this cycle", $time);
                end else begin
                    check_store(dbus_addr_o, exp_q[0].addr, dbus_wdata_o, exp_q[0].data);
                    void'(exp_q.pop_front());
                end
            end else if (exp_q.size() != 0 && exp_q[0].due == cycle_cnt) begin
                errors++;
                $display("expected store strobe missing at time %0t", $time);
                void'(exp_q.pop_front());
            end
        end
    end

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic reg_addr_t rand_reg();
        return reg_addr_t'(rand_below(POOL + 1));
    endfunction

    function automatic xlen_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                    input reg_addr_t rd, input reg_addr_t rs1,
                                    input reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, RV_OP};
    endfunction

    function automatic xlen_t enc_i(input logic [2:0] f3, input reg_addr_t rd,
                                    input reg_addr_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, RV_OP_IMM};
    endfunction

    function automatic xlen_t enc_sw(input reg_addr_t rs2, input reg_addr_t rs1,
                                     input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], RV_STORE};
    endfunction

    // Random kept ALU instruction, R-type or I-type by choice
    function automatic xlen_t rand_alu(input reg_addr_t rd, input logic use_imm);
        logic [2:0] r_f3 [0:5];
        logic [2:0] i_f3 [0:3];
        int k;
        r_f3 = '{3'b000, 3'b000, 3'b111, 3'b110, 3'b100, 3'b010};
        i_f3 = '{3'b000, 3'b111, 3'b110, 3'b100};
        if (use_imm) begin
            k = rand_below(4);
            return enc_i(i_f3[k], rd, rand_reg(), 12'($random(seed)));
        end
        k = rand_below(6);
        return enc_r((k == 1) ? 7'b0100000 : 7'b0000000, r_f3[k], rd, rand_reg(), rand_reg());
    endfunction

    function automatic xlen_t rand_unknown();
        xlen_t word;
        word = $random(seed);
        while (word[6:0] == RV_OP || word[6:0] == RV_OP_IMM || word[6:0] == RV_STORE) begin
            word = $random(seed);
        end
        // Aim rd at the pool so a stray write shows up in later stores
        word[11:7] = rand_reg();
        return word;
    endfunction

    // Sequential architectural model, applied when the instruction is driven
    task automatic model_apply(input xlen_t instr);
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        xlen_t      a;
        xlen_t      b;
        xlen_t      imm;
        xlen_t      res;
        logic       we;
        opc = instr[6:0];
        f3  = instr[14:12];
        f7  = instr[31:25];
        a   = model_regs[instr[19:15]];
        b   = model_regs[instr[24:20]];
        we  = 1'b0;
        res = '0;
        if (opc == RV_OP && (f7 == 7'b0000000 || (f7 == 7'b0100000 && f3 == 3'b000))) begin
            we = 1'b1;
            case (f3)
                3'b000:  res = (f7 == 7'b0100000) ? a - b : a + b;
                3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                3'b100:  res = a ^ b;
                3'b110:  res = a | b;
                3'b111:  res = a & b;
                default: we = 1'b0;
            endcase
        end else if (opc == RV_OP_IMM) begin
            imm = {{20{instr[31]}}, instr[31:20]};
            we  = 1'b1;
            case (f3)
                3'b000:  res = a + imm;
                3'b100:  res = a ^ imm;
                3'b110:  res = a | imm;
                3'b111:  res = a & imm;
                default: we = 1'b0;
            endcase
        end else if (opc == RV_STORE && f3 == 3'b010) begin
            imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            exp_q.push_back({cycle_cnt + 32'd3, a + imm, b});
        end
        if (we && instr[11:7] != 5'd0) begin
            model_regs[instr[11:7]] = res;
        end
    endtask

    task automatic issue(input xlen_t instr);
        @(posedge clk);
        #1;
        instr_valid_i = 1'b1;
        instr_i       = instr;
        model_apply(instr);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            instr_valid_i = 1'b0;
            instr_i       = $random(seed);
        end
    endtask

    // Wait until every expected store has been seen
    task automatic drain();
        idle(1);
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic report_test(input string name);
        drain();
        $display("test %s done, %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    initial begin
        reg_addr_t rd;
        seed          = 32'h1ada9b97;
        clk           = 1'b0;
        rst_n         = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        cycle_cnt     = '0;
        checks        = 0;
        errors        = 0;
        err_mark      = 0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        idle(IDLE_CYCLES);
        for (int i = 0; i < `REG_COUNT; i++) begin
            issue(enc_sw(reg_addr_t'(i), 5'd0, 12'(4 * i)));
        end
        report_test("reset_state");

        // Seed the pool so the ALU has nonzero operands
        for (int i = 1; i <= POOL; i++) begin
            issue(enc_i(3'b000, reg_addr_t'(i), 5'd0, 12'($random(seed))));
        end
        for (int i = 0; i < N_RR; i++) begin
            rd = reg_addr_t'(1 + rand_below(POOL));
            issue(rand_alu(rd, 1'b0));
            issue(enc_sw(rd, rand_reg(), 12'd0));
        end
        report_test("reg_reg_forwarding");

        for (int i = 0; i < N_IMM; i++) begin
            rd = reg_addr_t'(1 + rand_below(POOL));
            issue(rand_alu(rd, 1'b1));
            issue(enc_sw(rd, rand_reg(), 12'($random(seed))));
        end
        report_test("immediate_and_offsets");

        for (int i = 0; i < N_X0; i++) begin
            issue(rand_alu(5'd0, i >= 6));
            issue(enc_sw(5'd0, rand_reg(), 12'($random(seed))));
        end
        report_test("x0_writes");

        for (int i = 0; i < N_GAP; i++) begin
            rd = reg_addr_t'(1 + rand_below(POOL));
            idle(rand_below(MAX_GAP + 1));
            issue(rand_alu(rd, rand_below(2) == 1));
            idle(rand_below(MAX_GAP + 1));
            issue(enc_sw(rd, rand_reg(), 12'($random(seed))));
        end
        report_test("idle_gaps");

        for (int i = 0; i < N_UNK; i++) begin
            issue(rand_unknown());
            issue(enc_sw(rand_reg(), rand_reg(), 12'($random(seed))));
        end
        report_test("unknown_opcodes");

        $display("tests: 6, store checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule : core_tb

// File: list.f
+incdir+logic
logic/core_pkg.sv
logic/id2exe_if.sv
logic/reg_file.sv
logic/instr_decode.sv
logic/int_execute.sv
logic/core_top.sv
verif/core_tb.sv

// File: Bender.yml
package:
  name: core

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/core_pkg.sv
      - logic/id2exe_if.sv
      - logic/reg_file.sv
      - logic/instr_decode.sv
      - logic/int_execute.sv
      - logic/core_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/core_tb.sv
